//--- src/glbl_map_pkg.sv
// ----------------------------
// Global register map package
// Word indices, reset values, chip ID and control bit positions
// ----------------------------
`default_nettype none

package glbl_map_pkg;

  // ----------------------------
  // Register word indices
  // ----------------------------
  // Indices 8 to 15 are unmapped and read as zero
  typedef enum logic [3:0] {
    idx_chip_id   = 4'd0,
    idx_glbl_ctrl = 4'd1,
    idx_core_cfg  = 4'd2,
    idx_irq_mask  = 4'd3,
    idx_irq_stat  = 4'd4,
    idx_mux_sel   = 4'd5,
    idx_scratch_0 = 4'd6,
    idx_scratch_1 = 4'd7
  } reg_idx_e;

  // ----------------------------
  // Chip identification
  // ----------------------------
  // Manufacturer code, ASCII "RC"
  localparam logic [15:0] chip_manu_id   = 16'h5243;
  localparam logic [3:0]  chip_num_cores = 4'h1;
  localparam logic [3:0]  chip_num       = 4'h2;
  localparam logic [7:0]  chip_rev       = 8'h01;
  localparam logic [31:0] chip_id_val    = {chip_manu_id, chip_num_cores, chip_num, chip_rev};

  // Scratch reset values
  // ASCII "RISC" in scratch 0, firmware revision 1.0 in scratch 1
  localparam logic [31:0] scratch_0_rst = 32'h5249_5343;
  localparam logic [31:0] scratch_1_rst = 32'h0001_0000;

  // ----------------------------
  // glbl_ctrl bit positions
  // ----------------------------
  // All resets active low, so zero holds the block in reset
  localparam int rst_bit_core1    = 9;
  localparam int rst_bit_core0    = 8;
  localparam int rst_bit_qspi     = 6;
  localparam int rst_bit_spi      = 5;
  localparam int rst_bit_uart0    = 4;
  localparam int rst_bit_uart1    = 3;
  localparam int rst_bit_i2c      = 2;
  localparam int rst_bit_usb      = 1;
  localparam int rst_bit_cpu_intf = 0;
  localparam int num_periph_rst   = 7;

  // Low bit of 16-bit core configuration field
  localparam int core_cfg_lsb = 16;

endpackage

`default_nettype wire

//--- src/glbl_irq_pkg.sv
// ----------------------------
// Interrupt and bridge package
// Status layout and bus bridge state type
// ----------------------------
`default_nettype none

package glbl_irq_pkg;

  // Hardware interrupt sources
  localparam int num_hw_irq = 8;

  // Positions within the hardware vector
  localparam int hw_irq_timer_lsb = 0;
  localparam int hw_irq_i2c       = 3;
  localparam int hw_irq_usb       = 4;
  localparam int hw_irq_ext_lsb   = 5;
  localparam int hw_irq_gpio      = 7;

  // Software owned status bits, above the hardware byte
  localparam int soft_irq_bit = 8;
  localparam int user_irq_lsb = 9;
  localparam int stat_width   = 12;

  // Wishbone bridge FSM states
  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    done = 2'd2
  } bridge_state_e;

endpackage

`default_nettype wire

//--- src/byte_en_reg.sv
// ----------------------------
// 32-bit register, byte write enables
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module byte_en_reg #(
  parameter logic [31:0] rst_val = 32'h0
) (
  input  logic        mclk,
  input  logic        h_reset_n,
  input  logic        wr_en,
  input  logic [3:0]  be,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  // Each byte loads on its own enable
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      rdata <= rst_val;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr_en && be[i]) begin
          rdata[i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/intr_stat_reg.sv
// ----------------------------
// Sticky hardware interrupt status
// Write one to clear, hardware set wins
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module intr_stat_reg import glbl_irq_pkg::*; (
  input  logic                  mclk,
  input  logic                  h_reset_n,
  input  logic                  clr_en,
  input  logic [num_hw_irq-1:0] clr_data,
  input  logic [num_hw_irq-1:0] hw_irq,
  output logic [num_hw_irq-1:0] stat
);

  // Bits to drop this cycle
  logic [num_hw_irq-1:0] clr_mask;
  assign clr_mask = {num_hw_irq{clr_en}} & clr_data;

  // ----------------------------
  // Status update
  // ----------------------------
  // Level sampled inputs, set applied after clear
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      stat <= '0;
    end else begin
      stat <= (stat & ~clr_mask) | hw_irq;
    end
  end

endmodule

`default_nettype wire

//--- src/wb_reg_bridge.sv
// ----------------------------
// Wishbone classic slave bridge
// One bus cycle becomes one register access
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module wb_reg_bridge import glbl_irq_pkg::*; (
  input  logic        mclk,
  input  logic        h_reset_n,
  // Wishbone slave side
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [5:0]  wb_adr,
  input  logic [3:0]  wb_sel,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack,
  // Register bus side
  output logic        reg_cs,
  output logic        reg_wr,
  output logic [3:0]  reg_addr,
  output logic [31:0] reg_wdata,
  output logic [3:0]  reg_be,
  input  logic [31:0] reg_rdata,
  input  logic        reg_ack
);

  bridge_state_e state;

  // Request seen in idle
  logic req_start;
  assign req_start = (state == idle) && wb_cyc && wb_stb;

  // ----------------------------
  // Control FSM
  // ----------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      state  <= idle;
      reg_cs <= 1'b0;
      wb_ack <= 1'b0;
    end else begin
      // Ack is a single cycle pulse
      wb_ack <= 1'b0;
      case (state)
        idle: begin
          if (req_start) begin
            reg_cs <= 1'b1;
            state  <= busy;
          end
        end
        busy: begin
          // Hold request until register file answers
          if (reg_ack) begin
            reg_cs <= 1'b0;
            wb_ack <= 1'b1;
            state  <= done;
          end
        end
        done: begin
          // Wait for strobe to drop, no second ack
          if (!wb_stb) begin
            state <= idle;
          end
        end
        default: begin
          reg_cs <= 1'b0;
          state  <= idle;
        end
      endcase
    end
  end

  // Request fields, latched once per cycle
  always_ff @(posedge mclk) begin
    if (req_start) begin
      reg_wr    <= wb_we;
      reg_addr  <= wb_adr[5:2];
      reg_wdata <= wb_dat_i;
      reg_be    <= wb_sel;
    end
  end

  // Read data returned with the ack
  always_ff @(posedge mclk) begin
    if (state == busy && reg_ack) begin
      wb_dat_o <= reg_rdata;
    end
  end

endmodule

`default_nettype wire

//--- src/glbl_reg.sv
// ----------------------------
// Global register file
// Decode, read mux, ack, reset and interrupt outputs
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module glbl_reg import glbl_map_pkg::*; import glbl_irq_pkg::*; (
  input  logic                      mclk,
  input  logic                      h_reset_n,
  // Register bus
  input  logic                      reg_cs,
  input  logic                      reg_wr,
  input  logic [3:0]                reg_addr,
  input  logic [31:0]               reg_wdata,
  input  logic [3:0]                reg_be,
  output logic [31:0]               reg_rdata,
  output logic                      reg_ack,
  // Hardware interrupt vector
  input  logic [num_hw_irq-1:0]     hw_irq,
  // Control outputs
  output logic [1:0]                core_rst_n,
  output logic [num_periph_rst-1:0] periph_rst_n,
  output logic [15:0]               core_cfg,
  output logic [31:0]               mux_sel,
  output logic [num_hw_irq-1:0]     irq_lines,
  output logic                      soft_irq,
  output logic [2:0]                user_irq
);

  // ----------------------------
  // Access qualification
  // ----------------------------
  // Access happens on the edge where reg_ack rises
  logic acc_en;
  logic acc_wr;
  assign acc_en = reg_cs && !reg_ack;
  assign acc_wr = acc_en && reg_wr;

  // One-hot write strobes per word index
  logic [15:0] wr_dec;
  always_comb begin
    wr_dec = '0;
    if (acc_wr) begin
      wr_dec[reg_addr] = 1'b1;
    end
  end

  // Register contents
  logic [31:0] glbl_ctrl_q;
  logic [31:0] core_cfg_q;
  logic [31:0] irq_mask_q;
  logic [31:0] mux_sel_q;
  logic [31:0] scratch_0_q;
  logic [31:0] scratch_1_q;
  logic [num_hw_irq-1:0] hw_stat;
  logic                  soft_bit;
  logic [2:0]            user_bits;
  logic [stat_width-1:0] stat_word;
  logic [31:0]           rd_mux;

  // ----------------------------
  // Plain byte-enabled registers
  // ----------------------------
  // Reset and core config
  byte_en_reg #(.rst_val(32'h0)) u_glbl_ctrl (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr_en     (wr_dec[idx_glbl_ctrl]),
    .be        (reg_be),
    .wdata     (reg_wdata),
    .rdata     (glbl_ctrl_q)
  );

  byte_en_reg #(.rst_val(32'h0)) u_core_cfg (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr_en     (wr_dec[idx_core_cfg]),
    .be        (reg_be),
    .wdata     (reg_wdata),
    .rdata     (core_cfg_q)
  );

  // Interrupt mask, same layout as status
  byte_en_reg #(.rst_val(32'h0)) u_irq_mask (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr_en     (wr_dec[idx_irq_mask]),
    .be        (reg_be),
    .wdata     (reg_wdata),
    .rdata     (irq_mask_q)
  );

  // Pin function select
  byte_en_reg #(.rst_val(32'h0)) u_mux_sel (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr_en     (wr_dec[idx_mux_sel]),
    .be        (reg_be),
    .wdata     (reg_wdata),
    .rdata     (mux_sel_q)
  );

  // Software scratch words
  byte_en_reg #(.rst_val(scratch_0_rst)) u_scratch_0 (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr_en     (wr_dec[idx_scratch_0]),
    .be        (reg_be),
    .wdata     (reg_wdata),
    .rdata     (scratch_0_q)
  );

  byte_en_reg #(.rst_val(scratch_1_rst)) u_scratch_1 (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wr_en     (wr_dec[idx_scratch_1]),
    .be        (reg_be),
    .wdata     (reg_wdata),
    .rdata     (scratch_1_q)
  );

  // ----------------------------
  // Interrupt status
  // ----------------------------
  // Hardware byte, W1C through byte 0
  intr_stat_reg u_irq_stat (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr_en    (wr_dec[idx_irq_stat] && reg_be[0]),
    .clr_data  (reg_wdata[num_hw_irq-1:0]),
    .hw_irq    (hw_irq),
    .stat      (hw_stat)
  );

  // Soft and user bits live in byte 1, written directly
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      soft_bit  <= 1'b0;
      user_bits <= 3'b0;
    end else if (wr_dec[idx_irq_stat] && reg_be[1]) begin
      soft_bit  <= reg_wdata[soft_irq_bit];
      user_bits <= reg_wdata[user_irq_lsb +: 3];
    end
  end

  always_comb begin
    stat_word                     = '0;
    stat_word[num_hw_irq-1:0]     = hw_stat;
    stat_word[soft_irq_bit]       = soft_bit;
    stat_word[user_irq_lsb +: 3]  = user_bits;
  end

  // Masked lines to the core
  assign irq_lines = irq_mask_q[num_hw_irq-1:0] & stat_word[num_hw_irq-1:0];
  assign soft_irq  = irq_mask_q[soft_irq_bit] & stat_word[soft_irq_bit];
  assign user_irq  = irq_mask_q[user_irq_lsb +: 3] & stat_word[user_irq_lsb +: 3];

  // ----------------------------
  // Control outputs
  // ----------------------------
  assign core_rst_n = {glbl_ctrl_q[rst_bit_core1], glbl_ctrl_q[rst_bit_core0]};

  always_comb begin
    periph_rst_n                   = '0;
    periph_rst_n[rst_bit_qspi]     = glbl_ctrl_q[rst_bit_qspi];
    periph_rst_n[rst_bit_spi]      = glbl_ctrl_q[rst_bit_spi];
    periph_rst_n[rst_bit_uart0]    = glbl_ctrl_q[rst_bit_uart0];
    periph_rst_n[rst_bit_uart1]    = glbl_ctrl_q[rst_bit_uart1];
    periph_rst_n[rst_bit_i2c]      = glbl_ctrl_q[rst_bit_i2c];
    periph_rst_n[rst_bit_usb]      = glbl_ctrl_q[rst_bit_usb];
    periph_rst_n[rst_bit_cpu_intf] = glbl_ctrl_q[rst_bit_cpu_intf];
  end

  assign core_cfg = core_cfg_q[core_cfg_lsb +: 16];
  assign mux_sel  = mux_sel_q;

  // ----------------------------
  // Read path
  // ----------------------------
  // Unmapped indices read zero
  always_comb begin
    case (reg_addr)
      idx_chip_id:   rd_mux = chip_id_val;
      idx_glbl_ctrl: rd_mux = glbl_ctrl_q;
      idx_core_cfg:  rd_mux = core_cfg_q;
      idx_irq_mask:  rd_mux = irq_mask_q;
      idx_irq_stat:  rd_mux = 32'(stat_word);
      idx_mux_sel:   rd_mux = mux_sel_q;
      idx_scratch_0: rd_mux = scratch_0_q;
      idx_scratch_1: rd_mux = scratch_1_q;
      default:       rd_mux = 32'h0;
    endcase
  end

  // One cycle ack per chip select
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= acc_en;
    end
  end

  // Read data captured with the ack
  always_ff @(posedge mclk) begin
    if (acc_en) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- src/glbl_ctrl_top.sv
// ----------------------------
// Global control block top
// Wishbone bridge plus register file
// ----------------------------
`timescale 1ns/1ns
`default_nettype none

module glbl_ctrl_top import glbl_map_pkg::*; import glbl_irq_pkg::*; (
  input  logic                      mclk,
  input  logic                      h_reset_n,
  // Wishbone slave
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [5:0]                wb_adr,
  input  logic [3:0]                wb_sel,
  input  logic [31:0]               wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack,
  // Interrupt sources
  input  logic [1:0]                ext_intr,
  input  logic [2:0]                timer_intr,
  input  logic                      i2cm_intr,
  input  logic                      usb_intr,
  input  logic                      gpio_intr,
  // Control outputs
  output logic [1:0]                core_rst_n,
  output logic [num_periph_rst-1:0] periph_rst_n,
  output logic [15:0]               core_cfg,
  output logic [31:0]               mux_sel,
  output logic [num_hw_irq-1:0]     irq_lines,
  output logic                      soft_irq,
  output logic [2:0]                user_irq
);

  // Register bus
  logic        reg_cs;
  logic        reg_wr;
  logic [3:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [3:0]  reg_be;
  logic [31:0] reg_rdata;
  logic        reg_ack;

  // Hardware vector in status bit order
  logic [num_hw_irq-1:0] hw_irq;
  assign hw_irq[hw_irq_timer_lsb +: 3] = timer_intr;
  assign hw_irq[hw_irq_i2c]            = i2cm_intr;
  assign hw_irq[hw_irq_usb]            = usb_intr;
  assign hw_irq[hw_irq_ext_lsb +: 2]   = ext_intr;
  assign hw_irq[hw_irq_gpio]           = gpio_intr;

  wb_reg_bridge u_bridge (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_sel    (wb_sel),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack)
  );

  glbl_reg u_glbl_reg (
    .mclk         (mclk),
    .h_reset_n    (h_reset_n),
    .reg_cs       (reg_cs),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_be       (reg_be),
    .reg_rdata    (reg_rdata),
    .reg_ack      (reg_ack),
    .hw_irq       (hw_irq),
    .core_rst_n   (core_rst_n),
    .periph_rst_n (periph_rst_n),
    .core_cfg     (core_cfg),
    .mux_sel      (mux_sel),
    .irq_lines    (irq_lines),
    .soft_irq     (soft_irq),
    .user_irq     (user_irq)
  );

endmodule

`default_nettype wire

//--- dv/glbl_ctrl_properties.sv
// ------------------------------
// Bus handshake and reset output assertions
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module glbl_ctrl_properties import glbl_map_pkg::*; (
  input logic                      mclk,
  input logic                      h_reset_n,
  input logic                      wb_cyc,
  input logic                      wb_stb,
  input logic                      wb_ack,
  input logic [1:0]                core_rst_n,
  input logic [num_periph_rst-1:0] periph_rst_n
);

  // Read back by the testbench summary
  int assert_fail_cnt = 0;

  // Ack rises on an edge where the request is still held
  ack_needs_req: assert property (@(posedge mclk) disable iff (!h_reset_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
  else begin
    $error("wb_ack rose without wb_cyc and wb_stb high");
    assert_fail_cnt++;
  end

  // Single cycle ack
  ack_one_cycle: assert property (@(posedge mclk) disable iff (!h_reset_n)
    wb_ack |=> !wb_ack)
  else begin
    $error("wb_ack high for two cycles");
    assert_fail_cnt++;
  end

  // Everything still held in reset right after release
  rst_out_low: assert property (@(posedge mclk)
    $rose(h_reset_n) |-> (core_rst_n == 2'b00) && (periph_rst_n == '0))
  else begin
    $error("reset outputs not low after reset release");
    assert_fail_cnt++;
  end

endmodule

bind glbl_ctrl_top glbl_ctrl_properties glbl_props_inst (
  .mclk         (mclk),
  .h_reset_n    (h_reset_n),
  .wb_cyc       (wb_cyc),
  .wb_stb       (wb_stb),
  .wb_ack       (wb_ack),
  .core_rst_n   (core_rst_n),
  .periph_rst_n (periph_rst_n)
);

`default_nettype wire

//--- dv/glbl_ctrl_tb.sv
// ------------------------------
// Global control block testbench
// File driven bus accesses and output port checks
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module glbl_ctrl_tb;

  localparam int clk_period      = 100;
  localparam int rst_cycles      = 8;
  localparam int rand_seed       = 28;
  localparam int ack_limit       = 10;
  localparam int cycles_per_line = 20;

  // DUT ports
  logic        mclk;
  logic        h_reset_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [5:0]  wb_adr;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack;
  logic [1:0]  ext_intr;
  logic [2:0]  timer_intr;
  logic        i2cm_intr;
  logic        usb_intr;
  logic        gpio_intr;
  logic [1:0]  core_rst_n;
  logic [6:0]  periph_rst_n;
  logic [15:0] core_cfg;
  logic [31:0] mux_sel;
  logic [7:0]  irq_lines;
  logic        soft_irq;
  logic [2:0]  user_irq;

  // Run bookkeeping
  int errors;
  int test_errs;
  int tests_passed;
  int tests_failed;
  int line_cnt;

  glbl_ctrl_top glbl_ctrl_top_inst (
    .mclk         (mclk),
    .h_reset_n    (h_reset_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .ext_intr     (ext_intr),
    .timer_intr   (timer_intr),
    .i2cm_intr    (i2cm_intr),
    .usb_intr     (usb_intr),
    .gpio_intr    (gpio_intr),
    .core_rst_n   (core_rst_n),
    .periph_rst_n (periph_rst_n),
    .core_cfg     (core_cfg),
    .mux_sel      (mux_sel),
    .irq_lines    (irq_lines),
    .soft_irq     (soft_irq),
    .user_irq     (user_irq)
  );

  // Free running clock
  initial begin
    mclk = 1'b0;
    forever #(clk_period / 2) mclk = ~mclk;
  end

  // Watchdog, budget scales with stimulus length
  initial begin
    wait (line_cnt > 0);
    #((line_cnt * cycles_per_line + rst_cycles) * clk_period);
    $display("Watchdog timeout: stimulus did not complete in the allowed time");
    $display("TESTS FAILED");
    $finish;
  end

  // ------------------------------
  // Checker and per test summary
  // ------------------------------
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic end_test(input int num);
    if (test_errs == 0) begin
      tests_passed++;
      $display("Test %0d passed", num);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d mismatches", num, test_errs);
    end
    test_errs = 0;
  endtask

  // ------------------------------
  // Bus and pin drivers
  // ------------------------------
  // Called on a falling edge, returns on one
  task automatic bus_cycle(input logic we, input logic hold, input logic [3:0] idx,
                           input logic [31:0] data, input logic [3:0] sel,
                           output logic [31:0] rdata);
    int edges;
    edges    = 0;
    rdata    = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = {idx, 2'b00};
    wb_sel   = sel;
    wb_dat_i = data;
    // Falling edges until ack shows
    do begin
      @(negedge mclk);
      edges++;
    end while (!wb_ack && edges < ack_limit);
    if (!wb_ack) begin
      $display("No wb_ack within %0d cycles for word index %0d", ack_limit, idx);
      errors++;
      test_errs++;
    end else begin
      // Request edge plus two register stages
      compare("wb_ack latency", edges, 32'd3);
      rdata = wb_dat_o;
    end
    // Stretched strobe, ack must stay low
    if (hold) begin
      @(negedge mclk);
      compare("wb_ack", 32'(wb_ack), 32'd0);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // At least one idle edge so the bridge leaves done
    repeat (1 + $urandom_range(0, 2)) @(negedge mclk);
  endtask

  // Vector order timer, i2c, usb, ext, gpio
  task automatic drive_irq(input logic [7:0] vec);
    timer_intr = vec[2:0];
    i2cm_intr  = vec[3];
    usb_intr   = vec[4];
    ext_intr   = vec[6:5];
    gpio_intr  = vec[7];
    @(negedge mclk);
  endtask

  task automatic check_port(input logic [3:0] code, input logic [31:0] exp);
    case (code)
      4'd0: compare("core_rst_n", 32'(core_rst_n), exp);
      4'd1: compare("periph_rst_n", 32'(periph_rst_n), exp);
      4'd2: compare("core_cfg", 32'(core_cfg), exp);
      4'd3: compare("mux_sel", mux_sel, exp);
      4'd4: compare("irq_lines", 32'(irq_lines), exp);
      4'd5: compare("soft_irq", 32'(soft_irq), exp);
      4'd6: compare("user_irq", 32'(user_irq), exp);
      default: begin
        $display("Stimulus names an unknown output port code %0d", code);
        errors++;
        test_errs++;
      end
    endcase
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int fd;
    int n;
    int cur_test;
    int test_num;
    int total;
    logic stop;
    logic [23:0] op;
    logic [31:0] arg;
    logic [31:0] data;
    logic [31:0] sel;
    logic [31:0] expv;
    logic [31:0] rdata;
    logic [8*128-1:0] line;
    void'($urandom(rand_seed));
    errors     = 0;
    test_errs  = 0;
    cur_test   = -1;
    stop       = 1'b0;
    h_reset_n  = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_sel     = '0;
    wb_dat_i   = '0;
    ext_intr   = '0;
    timer_intr = '0;
    i2cm_intr  = 1'b0;
    usb_intr   = 1'b0;
    gpio_intr  = 1'b0;
    // Line count sets the watchdog budget
    fd = $fopen("dv/glbl_testdata.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        line_cnt++;
      end
      $fclose(fd);
    end else begin
      $display("Could not open stimulus file dv/glbl_testdata.txt");
      errors++;
    end
    repeat (rst_cycles) @(negedge mclk);
    h_reset_n = 1'b1;
    if (line_cnt > 0) begin
      fd = $fopen("dv/glbl_testdata.txt", "r");
      while (!stop && $fscanf(fd, "%s", op) == 1) begin
        if (op == "###") begin
          void'($fgets(line, fd));
        end else begin
          n = $fscanf(fd, "%h %h %h %h %d", arg, data, sel, expv, test_num);
          if (n != 5) begin
            $display("Malformed stimulus line after operation %s", op);
            errors++;
            stop = 1'b1;
          end else begin
            if (test_num != cur_test) begin
              if (cur_test >= 0) begin
                end_test(cur_test);
              end
              cur_test = test_num;
            end
            case (op)
              "wri": bus_cycle(1'b1, 1'b0, arg[3:0], data, sel[3:0], rdata);
              "wrh": bus_cycle(1'b1, 1'b1, arg[3:0], data, sel[3:0], rdata);
              "rdc", "rdh": begin
                bus_cycle(1'b0, op == "rdh", arg[3:0], data, sel[3:0], rdata);
                compare($sformatf("wb_dat_o index %0d", arg[3:0]), rdata, expv);
              end
              "irq": drive_irq(arg[7:0]);
              "out": check_port(arg[3:0], expv);
              default: begin
                $display("Unknown stimulus operation %s in test %0d", op, test_num);
                errors++;
                test_errs++;
              end
            endcase
          end
        end
      end
      $fclose(fd);
      if (cur_test >= 0) begin
        end_test(cur_test);
      end
    end
    // Bound assertion failures count too
    total = errors + glbl_ctrl_top_inst.glbl_props_inst.assert_fail_cnt;
    $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
             tests_passed, tests_failed, glbl_ctrl_top_inst.glbl_props_inst.assert_fail_cnt);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/glbl_testdata.txt
### columns: op arg data sel expect test, all hex except the decimal test number
### op: wri/wrh write, rdc/rdh read and compare (h holds the strobe), irq inputs, out port
### out arg: 0 core_rst_n 1 periph_rst_n 2 core_cfg 3 mux_sel 4 irq_lines 5 soft_irq 6 user_irq
### irq arg bits: 2:0 timer 3 i2cm 4 usb 6:5 ext 7 gpio
rdc 0 0 f 52431201 1
rdc 1 0 f 00000000 1
rdc 4 0 f 00000000 1
rdc 6 0 f 52495343 1
rdc 7 0 f 00010000 1
out 0 0 0 00000000 1
out 1 0 0 00000000 1
out 4 0 0 00000000 1
out 5 0 0 00000000 1
out 6 0 0 00000000 1
wri 1 aaaa037f 3 00000000 2
rdc 1 0 f 0000037f 2
out 0 0 0 00000003 2
out 1 0 0 0000007f 2
wri 2 abcd1234 c 00000000 2
out 2 0 0 0000abcd 2
wri 5 11223344 5 00000000 2
wri 5 55667788 8 00000000 2
rdc 5 0 f 55220044 2
out 3 0 0 55220044 2
wri 6 deadbeef 2 00000000 2
rdc 6 0 f 5249be43 2
wri 3 000005a5 f 00000000 3
irq 03 0 0 00000000 3
irq 00 0 0 00000000 3
rdc 4 0 f 00000003 3
irq a0 0 0 00000000 3
irq 00 0 0 00000000 3
rdc 4 0 f 000000a3 3
out 4 0 0 000000a1 3
wri 4 00000021 1 00000000 3
rdc 4 0 f 00000082 3
out 4 0 0 00000080 3
wri 4 00000f00 2 00000000 3
rdc 4 0 f 00000f82 3
out 5 0 0 00000001 3
out 6 0 0 00000002 3
irq 10 0 0 00000000 4
wri 4 00000010 1 00000000 4
rdc 4 0 f 00000f92 4
irq 00 0 0 00000000 4
wri 4 00000010 1 00000000 4
rdc 4 0 f 00000f82 4
rdc 8 0 f 00000000 5
rdc f 0 f 00000000 5
wri 9 ffffffff f 00000000 5
wri 0 ffffffff f 00000000 5
rdc 0 0 f 52431201 5
rdc 1 0 f 0000037f 5
rdc 4 0 f 00000f82 5
rdc 7 0 f 00010000 5
rdh 6 0 f 5249be43 6
wrh 7 12345678 f 00000000 6
rdc 7 0 f 12345678 6

//--- src.f
src/glbl_map_pkg.sv
src/glbl_irq_pkg.sv
src/byte_en_reg.sv
src/intr_stat_reg.sv
src/wb_reg_bridge.sv
src/glbl_reg.sv
src/glbl_ctrl_top.sv
dv/glbl_ctrl_properties.sv
dv/glbl_ctrl_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = glbl_ctrl_tb
FILELIST = src.f

.PHONY: simulate clean

# Echo the run and fail unless the pass line appears
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
